//--- project.f
common/delay_pkg.sv
logic/stall_lfsr.sv
delay_stage/stall_timer.sv
delay_stage/stage_ctrl.sv
delay_stage/delay_stage.sv
logic/axi_delayer.sv
testbench/tb_axi_delayer.sv

//--- Makefile
# Verilator build and run of the AXI channel delayer testbench

TOP := tb_axi_delayer

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 -f project.f --top-module $(TOP)

run: build
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "Simulation finished: FAIL" sim.log; then \
		echo "simulation failed"; exit 1; \
	fi
	@grep -q "Simulation finished: PASS" sim.log

lint:
	verilator --lint-only -Wall -f project.f --top-module $(TOP) --timing

clean:
	rm -rf obj_dir sim.log

//--- testbench/tb_axi_delayer.sv
// directed testbench for the AXI channel delayer with scoreboard and latency checks
`timescale 1ns/1ps
`default_nettype none

module tb_axi_delayer;

  localparam int CYCLE_LIMIT = 6000;
  localparam int FIXED = 2;
  // channel order AW, W, B, AR, R
  localparam int CH_W [5] = '{44, 37, 6, 44, 39};
  localparam string CH_NAME [5] = '{"aw", "w", "b", "ar", "r"};

  logic clk = 1'b0;
  logic rst_n_i = 1'b0;
  logic rand_en_i = 1'b0;
  logic aw_valid_i = 1'b0, w_valid_i = 1'b0, ar_valid_i = 1'b0;
  logic b_valid_m_i = 1'b0, r_valid_m_i = 1'b0;
  logic [3:0] aw_id_i = '0, ar_id_i = '0, b_id_m_i = '0, r_id_m_i = '0;
  logic [31:0] aw_addr_i = '0, ar_addr_i = '0, w_data_i = '0, r_data_m_i = '0;
  logic [7:0] aw_len_i = '0, ar_len_i = '0;
  logic [3:0] w_strb_i = '0;
  logic w_last_i = 1'b0, r_last_m_i = 1'b0;
  logic [1:0] b_resp_m_i = '0, r_resp_m_i = '0;
  logic aw_ready_m_i = 1'b1, w_ready_m_i = 1'b1, ar_ready_m_i = 1'b1;
  logic b_ready_i = 1'b1, r_ready_i = 1'b1;

  logic aw_ready_o, w_ready_o, ar_ready_o, b_ready_m_o, r_ready_m_o;
  logic aw_valid_m_o, w_valid_m_o, ar_valid_m_o, b_valid_o, r_valid_o;
  logic [3:0] aw_id_m_o, ar_id_m_o, b_id_o, r_id_o;
  logic [31:0] aw_addr_m_o, ar_addr_m_o, w_data_m_o, r_data_o;
  logic [7:0] aw_len_m_o, ar_len_m_o;
  logic [3:0] w_strb_m_o;
  logic w_last_m_o, r_last_o;
  logic [1:0] b_resp_o, r_resp_o;

  int errors = 0;
  int cycle = 0;
  // downstream ready behavior per channel: 0 low, 1 high, 2 random
  int ready_mode [5] = '{1, 1, 1, 1, 1};
  logic [43:0] exp_q [5][$];
  int acc_q [5][$];
  logic mode_q [5][$];
  logic offered [5] = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b0};

  logic [4:0] in_v, in_r, out_v, out_r;
  logic [43:0] in_d [5];
  logic [43:0] out_d [5];

  axi_delayer #(.FIXED_DELAY(4'(FIXED)), .LFSR_SEED(16'hACE1)) dut (.*);

  always #4 clk = ~clk;

  assign in_v = {r_valid_m_i, ar_valid_i, b_valid_m_i, w_valid_i, aw_valid_i};
  assign in_r = {r_ready_m_o, ar_ready_o, b_ready_m_o, w_ready_o, aw_ready_o};
  assign out_v = {r_valid_o, ar_valid_m_o, b_valid_o, w_valid_m_o, aw_valid_m_o};
  assign out_r = {r_ready_i, ar_ready_m_i, b_ready_i, w_ready_m_i, aw_ready_m_i};
  assign in_d[0] = 44'({aw_id_i, aw_addr_i, aw_len_i});
  assign in_d[1] = 44'({w_data_i, w_strb_i, w_last_i});
  assign in_d[2] = 44'({b_id_m_i, b_resp_m_i});
  assign in_d[3] = 44'({ar_id_i, ar_addr_i, ar_len_i});
  assign in_d[4] = 44'({r_id_m_i, r_data_m_i, r_resp_m_i, r_last_m_i});
  assign out_d[0] = 44'({aw_id_m_o, aw_addr_m_o, aw_len_m_o});
  assign out_d[1] = 44'({w_data_m_o, w_strb_m_o, w_last_m_o});
  assign out_d[2] = 44'({b_id_o, b_resp_o});
  assign out_d[3] = 44'({ar_id_m_o, ar_addr_m_o, ar_len_m_o});
  assign out_d[4] = 44'({r_id_o, r_data_o, r_resp_o, r_last_o});

  function automatic logic pick_ready(input int ch);
    if (ready_mode[ch] == 2) begin
      return 1'($urandom % 2);
    end
    return ready_mode[ch] == 1;
  endfunction

  // the subordinate and manager ready models
  always @(negedge clk) begin
    aw_ready_m_i = pick_ready(0);
    w_ready_m_i  = pick_ready(1);
    b_ready_i    = pick_ready(2);
    ar_ready_m_i = pick_ready(3);
    r_ready_i    = pick_ready(4);
  end

  // scoreboard step for one channel at a rising edge
  task automatic observe(input int ch);
    int lat;
    logic [43:0] exp;
    // a stage holds one beat, so it is ready exactly when nothing is inside
    if (in_r[ch] != (exp_q[ch].size() == 0)) begin
      errors++;
      $display("Fail %s ready expected %h got %h", CH_NAME[ch],
               exp_q[ch].size() == 0, in_r[ch]);
    end
    if (out_v[ch] && !offered[ch]) begin
      offered[ch] = 1'b1;
      if (exp_q[ch].size() == 0) begin
        errors++;
        $display("channel %s raised valid with no beat inside", CH_NAME[ch]);
      end else begin
        lat = cycle - acc_q[ch][0];
        if (!mode_q[ch][0] && lat != FIXED + 1) begin
          errors++;
          $display("Fail %s latency expected %h got %h", CH_NAME[ch], FIXED + 1, lat);
        end
        if (mode_q[ch][0] && (lat < 1 || lat > 16)) begin
          errors++;
          $display("channel %s random latency %0d is outside 1 to 16", CH_NAME[ch], lat);
        end
      end
    end
    if (out_v[ch] && out_r[ch] && exp_q[ch].size() != 0) begin
      exp = exp_q[ch].pop_front();
      void'(acc_q[ch].pop_front());
      void'(mode_q[ch].pop_front());
      offered[ch] = 1'b0;
      if (out_d[ch] != exp) begin
        errors++;
        $display("Fail %s payload expected %h got %h", CH_NAME[ch], exp, out_d[ch]);
      end
    end
    if (in_v[ch] && in_r[ch]) begin
      exp_q[ch].push_back(in_d[ch]);
      acc_q[ch].push_back(cycle);
      mode_q[ch].push_back(rand_en_i);
    end
  endtask

  always @(posedge clk) begin
    if (rst_n_i) begin
      for (int ch = 0; ch < 5; ch++) begin
        observe(ch);
      end
    end
    cycle++;
    if (cycle >= CYCLE_LIMIT) begin
      $display("timeout after %0d cycles, traffic did not drain", cycle);
      $display("errors: %0d", errors);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  task automatic set_in(input int ch, input logic v, input logic [43:0] d);
    case (ch)
      0: begin
        aw_valid_i = v;
        {aw_id_i, aw_addr_i, aw_len_i} = d;
      end
      1: begin
        w_valid_i = v;
        {w_data_i, w_strb_i, w_last_i} = d[36:0];
      end
      2: begin
        b_valid_m_i = v;
        {b_id_m_i, b_resp_m_i} = d[5:0];
      end
      3: begin
        ar_valid_i = v;
        {ar_id_i, ar_addr_i, ar_len_i} = d;
      end
      default: begin
        r_valid_m_i = v;
        {r_id_m_i, r_data_m_i, r_resp_m_i, r_last_m_i} = d[38:0];
      end
    endcase
  endtask

  function automatic logic [43:0] rand_payload(input int ch);
    logic [63:0] raw;
    raw = {$urandom, $urandom};
    return raw[43:0] & ((44'd1 << CH_W[ch]) - 44'd1);
  endfunction

  // called on a falling edge; returns on the falling edge after the transfer
  task automatic send_beat(input int ch, input logic [43:0] d);
    set_in(ch, 1'b1, d);
    while (!in_r[ch]) begin
      @(negedge clk);
    end
    @(negedge clk);
    set_in(ch, 1'b0, d);
  endtask

  task automatic stream(input int ch, input int n);
    repeat (n) begin
      repeat ($urandom % 3) @(negedge clk);
      send_beat(ch, rand_payload(ch));
    end
  endtask

  task automatic drain();
    while (exp_q[0].size() + exp_q[1].size() + exp_q[2].size()
           + exp_q[3].size() + exp_q[4].size() != 0) begin
      @(negedge clk);
    end
    @(negedge clk);
  endtask

  task automatic check_reset_values();
    if (out_v != 5'b0) begin
      errors++;
      $display("Fail valid outputs after reset expected %h got %h", 5'h0, out_v);
    end
    if (in_r != 5'h1f) begin
      errors++;
      $display("Fail ready outputs after reset expected %h got %h", 5'h1f, in_r);
    end
  endtask

  task automatic measure_fixed_latency();
    rand_en_i = 1'b0;
    send_beat(0, rand_payload(0));
    send_beat(3, rand_payload(3));
    drain();
  endtask

  task automatic hold_aw_backpressure();
    logic [43:0] sent;
    ready_mode[0] = 0;
    @(negedge clk);
    sent = rand_payload(0);
    send_beat(0, sent);
    while (!aw_valid_m_o) begin
      @(negedge clk);
    end
    repeat (10) begin
      @(negedge clk);
      if (!aw_valid_m_o) begin
        errors++;
        $display("Fail aw_valid_m_o under back-pressure expected %h got %h",
                 1'b1, aw_valid_m_o);
      end
      if (aw_ready_o) begin
        errors++;
        $display("Fail aw_ready_o under back-pressure expected %h got %h",
                 1'b0, aw_ready_o);
      end
      if (out_d[0] != sent) begin
        errors++;
        $display("Fail aw payload under back-pressure expected %h got %h",
                 sent, out_d[0]);
      end
    end
    ready_mode[0] = 1;
    drain();
  endtask

  task automatic push_random_writes();
    rand_en_i = 1'b1;
    ready_mode[0] = 2;
    ready_mode[1] = 2;
    fork
      stream(0, 60);
      stream(1, 60);
    join
    drain();
    ready_mode[0] = 1;
    ready_mode[1] = 1;
  endtask

  task automatic reverse_channel_traffic(input logic mode);
    rand_en_i = mode;
    ready_mode[2] = 2;
    ready_mode[4] = 2;
    fork
      stream(2, 30);
      stream(4, 30);
    join
    drain();
    ready_mode[2] = 1;
    ready_mode[4] = 1;
  endtask

  task automatic stall_b_pass_ar();
    rand_en_i = 1'b0;
    ready_mode[2] = 0;
    @(negedge clk);
    send_beat(2, rand_payload(2));
    repeat (3) send_beat(3, rand_payload(3));
    while (exp_q[3].size() != 0) begin
      @(negedge clk);
    end
    if (!b_valid_o) begin
      errors++;
      $display("Fail b_valid_o while held off expected %h got %h", 1'b1, b_valid_o);
    end
    ready_mode[2] = 1;
    drain();
  endtask

  initial begin
    void'($urandom(74771));
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst_n_i = 1'b1;
    check_reset_values();
    measure_fixed_latency();
    hold_aw_backpressure();
    push_random_writes();
    reverse_channel_traffic(1'b0);
    reverse_channel_traffic(1'b1);
    stall_b_pass_ar();
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- logic/axi_delayer.sv
// AXI channel delayer top with five delay stages and a shared stall LFSR
`timescale 1ns/1ps
`default_nettype none

module axi_delayer #(
  parameter logic [delay_pkg::STALL_W-1:0] FIXED_DELAY = 2,
  parameter logic [15:0]                   LFSR_SEED   = 16'hACE1
) (
  input  logic                         clk,
  input  logic                         rst_n_i,
  input  logic                         rand_en_i,
  // manager side
  input  logic                         aw_valid_i,
  input  logic [delay_pkg::ID_W-1:0]   aw_id_i,
  input  logic [delay_pkg::ADDR_W-1:0] aw_addr_i,
  input  logic [delay_pkg::LEN_W-1:0]  aw_len_i,
  output logic                         aw_ready_o,
  input  logic                         w_valid_i,
  input  logic [delay_pkg::DATA_W-1:0] w_data_i,
  input  logic [delay_pkg::STRB_W-1:0] w_strb_i,
  input  logic                         w_last_i,
  output logic                         w_ready_o,
  output logic                         b_valid_o,
  output logic [delay_pkg::ID_W-1:0]   b_id_o,
  output logic [delay_pkg::RESP_W-1:0] b_resp_o,
  input  logic                         b_ready_i,
  input  logic                         ar_valid_i,
  input  logic [delay_pkg::ID_W-1:0]   ar_id_i,
  input  logic [delay_pkg::ADDR_W-1:0] ar_addr_i,
  input  logic [delay_pkg::LEN_W-1:0]  ar_len_i,
  output logic                         ar_ready_o,
  output logic                         r_valid_o,
  output logic [delay_pkg::ID_W-1:0]   r_id_o,
  output logic [delay_pkg::DATA_W-1:0] r_data_o,
  output logic [delay_pkg::RESP_W-1:0] r_resp_o,
  output logic                         r_last_o,
  input  logic                         r_ready_i,
  // subordinate side
  output logic                         aw_valid_m_o,
  output logic [delay_pkg::ID_W-1:0]   aw_id_m_o,
  output logic [delay_pkg::ADDR_W-1:0] aw_addr_m_o,
  output logic [delay_pkg::LEN_W-1:0]  aw_len_m_o,
  input  logic                         aw_ready_m_i,
  output logic                         w_valid_m_o,
  output logic [delay_pkg::DATA_W-1:0] w_data_m_o,
  output logic [delay_pkg::STRB_W-1:0] w_strb_m_o,
  output logic                         w_last_m_o,
  input  logic                         w_ready_m_i,
  input  logic                         b_valid_m_i,
  input  logic [delay_pkg::ID_W-1:0]   b_id_m_i,
  input  logic [delay_pkg::RESP_W-1:0] b_resp_m_i,
  output logic                         b_ready_m_o,
  output logic                         ar_valid_m_o,
  output logic [delay_pkg::ID_W-1:0]   ar_id_m_o,
  output logic [delay_pkg::ADDR_W-1:0] ar_addr_m_o,
  output logic [delay_pkg::LEN_W-1:0]  ar_len_m_o,
  input  logic                         ar_ready_m_i,
  input  logic                         r_valid_m_i,
  input  logic [delay_pkg::ID_W-1:0]   r_id_m_i,
  input  logic [delay_pkg::DATA_W-1:0] r_data_m_i,
  input  logic [delay_pkg::RESP_W-1:0] r_resp_m_i,
  input  logic                         r_last_m_i,
  output logic                         r_ready_m_o
);

  // packed payload widths per channel
  localparam int AX_W = delay_pkg::ID_W + delay_pkg::ADDR_W + delay_pkg::LEN_W;
  localparam int W_W  = delay_pkg::DATA_W + delay_pkg::STRB_W + 1;
  localparam int B_W  = delay_pkg::ID_W + delay_pkg::RESP_W;
  localparam int R_W  = delay_pkg::ID_W + delay_pkg::DATA_W + delay_pkg::RESP_W + 1;

  logic [15:0]     lfsr_state;
  logic [AX_W-1:0] aw_in;
  logic [AX_W-1:0] aw_out;
  logic [W_W-1:0]  w_in;
  logic [W_W-1:0]  w_out;
  logic [B_W-1:0]  b_in;
  logic [B_W-1:0]  b_out;
  logic [AX_W-1:0] ar_in;
  logic [AX_W-1:0] ar_out;
  logic [R_W-1:0]  r_in;
  logic [R_W-1:0]  r_out;

  stall_lfsr #(
    .LFSR_SEED (LFSR_SEED)
  ) u_lfsr (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .state_o (lfsr_state)
  );

  assign aw_in = {aw_id_i, aw_addr_i, aw_len_i};
  assign w_in  = {w_data_i, w_strb_i, w_last_i};
  assign b_in  = {b_id_m_i, b_resp_m_i};
  assign ar_in = {ar_id_i, ar_addr_i, ar_len_i};
  assign r_in  = {r_id_m_i, r_data_m_i, r_resp_m_i, r_last_m_i};

  assign {aw_id_m_o, aw_addr_m_o, aw_len_m_o} = aw_out;
  assign {w_data_m_o, w_strb_m_o, w_last_m_o} = w_out;
  assign {b_id_o, b_resp_o}                   = b_out;
  assign {ar_id_m_o, ar_addr_m_o, ar_len_m_o} = ar_out;
  assign {r_id_o, r_data_o, r_resp_o, r_last_o} = r_out;

  // each stage draws its random count from an overlapping window of the LFSR,
  // offset by three bits per stage in AW, W, B, AR, R order
  delay_stage #(.WIDTH(AX_W), .FIXED_DELAY(FIXED_DELAY)) u_aw_stage (
    .clk (clk), .rst_n_i (rst_n_i), .rand_en_i (rand_en_i),
    .rand_count_i (lfsr_state[0 +: delay_pkg::STALL_W]),
    .valid_i (aw_valid_i),   .data_i (aw_in),  .ready_o (aw_ready_o),
    .valid_o (aw_valid_m_o), .data_o (aw_out), .ready_i (aw_ready_m_i)
  );

  delay_stage #(.WIDTH(W_W), .FIXED_DELAY(FIXED_DELAY)) u_w_stage (
    .clk (clk), .rst_n_i (rst_n_i), .rand_en_i (rand_en_i),
    .rand_count_i (lfsr_state[3 +: delay_pkg::STALL_W]),
    .valid_i (w_valid_i),   .data_i (w_in),  .ready_o (w_ready_o),
    .valid_o (w_valid_m_o), .data_o (w_out), .ready_i (w_ready_m_i)
  );

  // B and R run in the reverse direction, subordinate to manager
  delay_stage #(.WIDTH(B_W), .FIXED_DELAY(FIXED_DELAY)) u_b_stage (
    .clk (clk), .rst_n_i (rst_n_i), .rand_en_i (rand_en_i),
    .rand_count_i (lfsr_state[6 +: delay_pkg::STALL_W]),
    .valid_i (b_valid_m_i), .data_i (b_in),  .ready_o (b_ready_m_o),
    .valid_o (b_valid_o),   .data_o (b_out), .ready_i (b_ready_i)
  );

  delay_stage #(.WIDTH(AX_W), .FIXED_DELAY(FIXED_DELAY)) u_ar_stage (
    .clk (clk), .rst_n_i (rst_n_i), .rand_en_i (rand_en_i),
    .rand_count_i (lfsr_state[9 +: delay_pkg::STALL_W]),
    .valid_i (ar_valid_i),   .data_i (ar_in),  .ready_o (ar_ready_o),
    .valid_o (ar_valid_m_o), .data_o (ar_out), .ready_i (ar_ready_m_i)
  );

  delay_stage #(.WIDTH(R_W), .FIXED_DELAY(FIXED_DELAY)) u_r_stage (
    .clk (clk), .rst_n_i (rst_n_i), .rand_en_i (rand_en_i),
    .rand_count_i (lfsr_state[12 +: delay_pkg::STALL_W]),
    .valid_i (r_valid_m_i), .data_i (r_in),  .ready_o (r_ready_m_o),
    .valid_o (r_valid_o),   .data_o (r_out), .ready_i (r_ready_i)
  );

endmodule

`default_nettype wire

//--- delay_stage/delay_stage.sv
// one channel delay stage with payload register, controller and stall timer
`timescale 1ns/1ps
`default_nettype none

module delay_stage #(
  parameter int                            WIDTH       = 8,
  parameter logic [delay_pkg::STALL_W-1:0] FIXED_DELAY = 2
) (
  input  logic                          clk,
  input  logic                          rst_n_i,
  input  logic                          rand_en_i,
  input  logic [delay_pkg::STALL_W-1:0] rand_count_i,
  input  logic                          valid_i,
  input  logic [WIDTH-1:0]              data_i,
  output logic                          ready_o,
  output logic                          valid_o,
  output logic [WIDTH-1:0]              data_o,
  input  logic                          ready_i
);

  logic                          capture;
  logic                          expired;
  logic [delay_pkg::STALL_W-1:0] stall_count;
  logic [WIDTH-1:0]              data_q;

  // mode is sampled together with the beat on the accepting edge
  assign stall_count = rand_en_i ? rand_count_i : FIXED_DELAY;

  stage_ctrl u_ctrl (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .in_valid_i  (valid_i),
    .in_ready_o  (ready_o),
    .out_ready_i (ready_i),
    .out_valid_o (valid_o),
    .capture_o   (capture),
    .expired_i   (expired)
  );

  stall_timer u_timer (
    .clk       (clk),
    .rst_n_i   (rst_n_i),
    .load_i    (capture),
    .count_i   (stall_count),
    .expired_o (expired)
  );

  always_ff @(posedge clk) begin
    if (capture) begin
      data_q <= data_i;
    end
  end

  assign data_o = data_q;

  // a beat on offer keeps both valid and payload until the consumer takes it
  a_hold_on_stall : assert property (
    @(posedge clk) disable iff (!rst_n_i)
    (valid_o && !ready_i) |=> (valid_o && $stable(data_o))
  ) else $error("delay_stage dropped or changed a beat under back-pressure");

endmodule

`default_nettype wire

//--- delay_stage/stage_ctrl.sv
// per-channel FSM sequencing accept, stall and offer of one beat
`timescale 1ns/1ps
`default_nettype none

module stage_ctrl (
  input  logic clk,
  input  logic rst_n_i,
  input  logic in_valid_i,
  output logic in_ready_o,
  input  logic out_ready_i,
  output logic out_valid_o,
  output logic capture_o,
  input  logic expired_i
);

  delay_pkg::stage_state_e state_q;
  delay_pkg::stage_state_e state_d;

  // the stage holds a single beat, so it only listens upstream while empty
  assign in_ready_o  = (state_q == delay_pkg::IDLE);
  assign out_valid_o = (state_q == delay_pkg::OFFER);
  assign capture_o   = in_valid_i && in_ready_o;

  always_comb begin
    state_d = state_q;
    case (state_q)
      delay_pkg::IDLE: begin
        // a zero stall count moves the beat straight to the output
        if (capture_o) begin
          if (expired_i) begin
            state_d = delay_pkg::OFFER;
          end else begin
            state_d = delay_pkg::STALL;
          end
        end
      end
      delay_pkg::STALL: begin
        if (expired_i) begin
          state_d = delay_pkg::OFFER;
        end
      end
      delay_pkg::OFFER: begin
        // downstream back-pressure keeps us here with valid held high
        if (out_ready_i) begin
          state_d = delay_pkg::IDLE;
        end
      end
      default: begin
        state_d = delay_pkg::IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= delay_pkg::IDLE;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

`default_nettype wire

//--- delay_stage/stall_timer.sv
// stall down-counter with a load input and an expiry flag
`timescale 1ns/1ps
`default_nettype none

module stall_timer (
  input  logic                          clk,
  input  logic                          rst_n_i,
  input  logic                          load_i,
  input  logic [delay_pkg::STALL_W-1:0] count_i,
  output logic                          expired_o
);

  localparam logic [delay_pkg::STALL_W-1:0] CNT_ONE =
    {{(delay_pkg::STALL_W - 1){1'b0}}, 1'b1};

  // remaining stall cycles after the current one
  logic [delay_pkg::STALL_W-1:0] cnt_q;

  // the load cycle itself is the first stall cycle, so one less is kept
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cnt_q <= '0;
    end else if (load_i) begin
      if (count_i == '0) begin
        cnt_q <= '0;
      end else begin
        cnt_q <= count_i - CNT_ONE;
      end
    end else if (cnt_q != '0) begin
      cnt_q <= cnt_q - CNT_ONE;
    end
  end

  // during a load the flag reports a zero count at once,
  // which lets the controller skip the stall entirely
  assign expired_o = load_i ? (count_i == '0) : (cnt_q == '0);

  // the controller may only capture a new beat once the previous stall has run out
  a_load_when_idle : assert property (
    @(posedge clk) disable iff (!rst_n_i)
    load_i |-> (cnt_q == '0)
  ) else $error("stall_timer loaded while a count was still running");

endmodule

`default_nettype wire

//--- logic/stall_lfsr.sv
// free-running 16-bit Galois LFSR supplying pseudo-random stall counts
`timescale 1ns/1ps
`default_nettype none

module stall_lfsr #(
  parameter logic [15:0] LFSR_SEED = 16'hACE1
) (
  input  logic        clk,
  input  logic        rst_n_i,
  output logic [15:0] state_o
);

  // feedback mask for x^16 + x^14 + x^13 + x^11 + 1, a maximal-length polynomial
  localparam logic [15:0] TAPS = 16'hB400;

  logic [15:0] state_q;
  logic [15:0] state_d;

  // shift right and fold the outgoing bit back in through the tap mask
  always_comb begin
    state_d = {1'b0, state_q[15:1]};
    if (state_q[0]) begin
      state_d = state_d ^ TAPS;
    end
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= LFSR_SEED;
    end else begin
      state_q <= state_d;
    end
  end

  assign state_o = state_q;

  // the all-zero state is a lock-up point, it would freeze every random stall count
  a_lfsr_nonzero : assert property (
    @(posedge clk) disable iff (!rst_n_i)
    state_q != '0
  ) else $error("stall_lfsr reached the all-zero state");

endmodule

`default_nettype wire

//--- common/delay_pkg.sv
// AXI field widths, stall count width and the stage state type for the delayer
`default_nettype none

package delay_pkg;

  // reduced AXI field widths carried by the delayer
  localparam int ID_W   = 4;
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int STRB_W = DATA_W / 8;
  localparam int LEN_W  = 8;
  localparam int RESP_W = 2;

  // a stall count of this width lasts at most 15 cycles
  localparam int STALL_W = 4;

  // states of one channel stage
  // IDLE waits for an input beat, STALL holds it back, OFFER presents it downstream
  typedef enum logic [1:0] {
    IDLE  = 2'd0,
    STALL = 2'd1,
    OFFER = 2'd2
  } stage_state_e;

endpackage

`default_nettype wire
